// ==== source/save_state_pkg.sv ====
package save_state_pkg;

    // sizes of the architectural state bank.
    localparam int unsigned word_bits       = 16;
    localparam int unsigned state_words     = 16;
    localparam int unsigned state_addr_bits = 4;

    // snapshot storage holds one full bank per slot.
    localparam int unsigned slot_count         = 4;
    localparam int unsigned slot_bits          = 2;
    localparam int unsigned snapshot_addr_bits = slot_bits + state_addr_bits;

    typedef logic [word_bits-1:0]          word_t;
    typedef logic [state_addr_bits-1:0]    state_addr_t;
    typedef logic [slot_bits-1:0]          slot_t;
    typedef logic [snapshot_addr_bits-1:0] snapshot_addr_t; // slot in the upper bits.

    localparam state_addr_t last_state_addr = state_addr_t'(state_words - 1);

    // drain lets the final write land before stall drops.
    typedef enum logic [1:0] {
        idle,
        saving,
        loading,
        drain
    } copy_state_t;

endpackage : save_state_pkg

// ==== source/mem_port_if.sv ====
`timescale 1ns/1ps

// one synchronous single-port access: read data follows read_en by one cycle.
interface mem_port_if;

    logic                           read_en;
    logic                           write_en;
    save_state_pkg::snapshot_addr_t addr;
    save_state_pkg::word_t          write_data;
    save_state_pkg::word_t          read_data;

    modport requester (
        output read_en,
        output write_en,
        output addr,
        output write_data,
        input  read_data
    );

    modport responder (
        input  read_en,
        input  write_en,
        input  addr,
        input  write_data,
        output read_data
    );

endinterface : mem_port_if

// ==== source/state_bank.sv ====
`timescale 1ns/1ps

module state_bank (
    input  logic                        clock,
    input  logic                        core_write_en,
    input  save_state_pkg::state_addr_t core_write_addr,
    input  save_state_pkg::word_t       core_write_data,
    input  save_state_pkg::state_addr_t core_read_addr,
    output save_state_pkg::word_t       core_read_data,
    input  logic                        freeze,
    mem_port_if.responder               state_port
);

    save_state_pkg::word_t       bank [save_state_pkg::state_words];
    save_state_pkg::state_addr_t port_index;

    // the bank port only uses the word index, the slot bits stay zero.
    assign port_index = state_port.addr[save_state_pkg::state_addr_bits-1:0];

    assign core_read_data = bank[core_read_addr]; // core reads are combinational.

    always_ff @(posedge clock) begin
        // the core may not touch the bank while a copy runs.
        if (core_write_en && !freeze) begin
            bank[core_write_addr] <= core_write_data;
        end
        if (state_port.write_en) begin
            bank[port_index] <= state_port.write_data;
        end
    end

    always_ff @(posedge clock) begin
        if (state_port.read_en) begin
            state_port.read_data <= bank[port_index];
        end
    end

endmodule : state_bank

// ==== source/snapshot_ram.sv ====
`timescale 1ns/1ps

module snapshot_ram (
    input  logic          clock,
    mem_port_if.responder snapshot_port
);

    localparam int unsigned ram_words = save_state_pkg::slot_count * save_state_pkg::state_words;

    save_state_pkg::word_t mem [ram_words];

    // plain write plus registered read so the storage maps onto block RAM.
    always_ff @(posedge clock) begin
        if (snapshot_port.write_en) begin
            mem[snapshot_port.addr] <= snapshot_port.write_data;
        end
        if (snapshot_port.read_en) begin
            snapshot_port.read_data <= mem[snapshot_port.addr];
        end
    end

endmodule : snapshot_ram

// ==== source/save_state_controller.sv ====
`timescale 1ns/1ps

module save_state_controller (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  begin_save_state,
    input  logic                  begin_load_state,
    input  save_state_pkg::slot_t slot,
    output logic                  stall,
    mem_port_if.requester         state_port,
    mem_port_if.requester         snapshot_port
);

    save_state_pkg::copy_state_t state, next_state;
    save_state_pkg::slot_t       slot_q;

    save_state_pkg::state_addr_t state_index, next_state_index;
    logic                        state_read_en, next_state_read_en;
    logic                        state_write_en, next_state_write_en;

    save_state_pkg::state_addr_t snap_index, next_snap_index;
    logic                        snap_read_en, next_snap_read_en;
    logic                        snap_write_en, next_snap_write_en;

    logic                        start;

    assign start = (state == save_state_pkg::idle) && (begin_save_state || begin_load_state);

    // low only when idle with no strobe pending.
    assign stall = (state != save_state_pkg::idle) || begin_save_state || begin_load_state;

    // each port writes what the other port just read, with no storage in between.
    assign state_port.write_data    = snapshot_port.read_data;
    assign snapshot_port.write_data = state_port.read_data;

    assign state_port.read_en  = state_read_en;
    assign state_port.write_en = state_write_en;
    assign state_port.addr     = {{save_state_pkg::slot_bits{1'b0}}, state_index};

    assign snapshot_port.read_en  = snap_read_en;
    assign snapshot_port.write_en = snap_write_en;
    assign snapshot_port.addr     = {slot_q, snap_index};

    always_comb begin
        next_state          = save_state_pkg::idle;
        next_state_index    = '0;
        next_state_read_en  = 1'b0;
        next_state_write_en = 1'b0;
        next_snap_index     = '0;
        next_snap_read_en   = 1'b0;
        next_snap_write_en  = 1'b0;
        case (state)
            save_state_pkg::idle: begin
                if (begin_save_state) begin // save wins over a load in the same cycle.
                    next_state         = save_state_pkg::saving;
                    next_state_read_en = 1'b1;
                end else if (begin_load_state) begin
                    next_state        = save_state_pkg::loading;
                    next_snap_read_en = 1'b1;
                end
            end
            save_state_pkg::saving: begin
                // the word read last cycle goes to the same index in the slot.
                next_snap_index    = state_index;
                next_snap_write_en = 1'b1;
                if (state_index == save_state_pkg::last_state_addr) begin
                    next_state = save_state_pkg::drain;
                end else begin
                    next_state         = save_state_pkg::saving;
                    next_state_read_en = 1'b1;
                    next_state_index   = state_index + 1'b1;
                end
            end
            save_state_pkg::loading: begin
                next_state_index    = snap_index;
                next_state_write_en = 1'b1;
                if (snap_index == save_state_pkg::last_state_addr) begin
                    next_state = save_state_pkg::drain;
                end else begin
                    next_state        = save_state_pkg::loading;
                    next_snap_read_en = 1'b1;
                    next_snap_index   = snap_index + 1'b1;
                end
            end
            save_state_pkg::drain: begin
                next_state = save_state_pkg::idle; // the last write lands on this edge.
            end
            default: begin
                next_state = save_state_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            state          <= save_state_pkg::idle;
            slot_q         <= '0;
            state_index    <= '0;
            state_read_en  <= 1'b0;
            state_write_en <= 1'b0;
            snap_index     <= '0;
            snap_read_en   <= 1'b0;
            snap_write_en  <= 1'b0;
        end else begin
            state          <= next_state;
            state_index    <= next_state_index;
            state_read_en  <= next_state_read_en;
            state_write_en <= next_state_write_en;
            snap_index     <= next_snap_index;
            snap_read_en   <= next_snap_read_en;
            snap_write_en  <= next_snap_write_en;
            if (start) begin
                slot_q <= slot; // held for the whole copy.
            end
        end
    end

endmodule : save_state_controller

// ==== source/save_state_top.sv ====
`timescale 1ns/1ps

module save_state_top (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic                        core_write_en,
    input  save_state_pkg::state_addr_t core_write_addr,
    input  save_state_pkg::word_t       core_write_data,
    input  save_state_pkg::state_addr_t core_read_addr,
    output save_state_pkg::word_t       core_read_data,
    input  logic                        begin_save_state,
    input  logic                        begin_load_state,
    input  save_state_pkg::slot_t       slot,
    output logic                        stall
);

    mem_port_if state_port ();
    mem_port_if snapshot_port ();

    save_state_controller i_controller (
        .clock            (clock),
        .reset_n          (reset_n),
        .begin_save_state (begin_save_state),
        .begin_load_state (begin_load_state),
        .slot             (slot),
        .stall            (stall),
        .state_port       (state_port.requester),
        .snapshot_port    (snapshot_port.requester)
    );

    // stall doubles as the freeze that blocks core writes during a copy.
    state_bank i_state_bank (
        .clock           (clock),
        .core_write_en   (core_write_en),
        .core_write_addr (core_write_addr),
        .core_write_data (core_write_data),
        .core_read_addr  (core_read_addr),
        .core_read_data  (core_read_data),
        .freeze          (stall),
        .state_port      (state_port.responder)
    );

    snapshot_ram i_snapshot_ram (
        .clock         (clock),
        .snapshot_port (snapshot_port.responder)
    );

endmodule : save_state_top

// ==== verification/save_state_props.sv ====
`timescale 1ns/1ps

module save_state_props (
    input logic                           clock,
    input logic                           reset_n,
    input logic                           stall,
    input save_state_pkg::copy_state_t    state,
    input save_state_pkg::slot_t          slot_q,
    input logic                           state_write_en,
    input logic                           snap_write_en,
    input save_state_pkg::snapshot_addr_t state_addr,
    input save_state_pkg::snapshot_addr_t snap_addr
);

    localparam int unsigned max_busy = save_state_pkg::state_words + 2;

    int unsigned busy_count; // cycles spent away from idle in the current copy.

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            busy_count <= '0;
        end else if (state == save_state_pkg::idle) begin
            busy_count <= '0;
        end else begin
            busy_count <= busy_count + 1;
        end
    end

    // any write on either port belongs to a running copy.
    stall_while_busy: assert property (
        @(posedge clock) disable iff (!reset_n)
        (state_write_en || snap_write_en) |-> stall
    ) else $error("stall is low while a copy writes");

    // a copy writes one side only, never both.
    single_writer: assert property (
        @(posedge clock) disable iff (!reset_n)
        !(state_write_en && snap_write_en)
    ) else $error("both ports write in the same cycle");

    // a saved word lands at the index the bank read one cycle before.
    save_index_follows_read: assert property (
        @(posedge clock) disable iff (!reset_n)
        snap_write_en |->
            (snap_addr[save_state_pkg::state_addr_bits-1:0]
             == $past(state_addr[save_state_pkg::state_addr_bits-1:0]))
    ) else $error("snapshot write index differs from the bank read index");

    load_index_follows_read: assert property (
        @(posedge clock) disable iff (!reset_n)
        state_write_en |->
            (state_addr[save_state_pkg::state_addr_bits-1:0]
             == $past(snap_addr[save_state_pkg::state_addr_bits-1:0]))
    ) else $error("bank write index differs from the snapshot read index");

    // the slot latched at the start holds until the copy ends.
    slot_held: assert property (
        @(posedge clock) disable iff (!reset_n)
        (state != save_state_pkg::idle && $past(state) != save_state_pkg::idle) |->
            $stable(slot_q)
    ) else $error("latched slot changed during a copy");

    idle_in_time: assert property (
        @(posedge clock) disable iff (!reset_n)
        busy_count < max_busy
    ) else $error("copy did not return to idle in time");

endmodule : save_state_props

// ==== verification/save_state_tb.sv ====
`timescale 1ns/1ps

module save_state_tb;

    localparam int timeout_cycles = 100;
    localparam int copy_cycles    = int'(save_state_pkg::state_words) + 2;
    localparam int inject_cycle   = 5; // busy cycle at which a stray strobe is given.

    logic                        clock;
    logic                        reset_n;
    logic                        core_write_en;
    save_state_pkg::state_addr_t core_write_addr;
    save_state_pkg::word_t       core_write_data;
    save_state_pkg::state_addr_t core_read_addr;
    save_state_pkg::word_t       core_read_data;
    logic                        begin_save_state;
    logic                        begin_load_state;
    save_state_pkg::slot_t       slot;
    logic                        stall;

    // expected contents of the bank and of every snapshot slot.
    save_state_pkg::word_t model_bank [save_state_pkg::state_words];
    save_state_pkg::word_t model_snap [save_state_pkg::slot_count][save_state_pkg::state_words];
    save_state_pkg::slot_t order [save_state_pkg::slot_count];

    integer seed           = 32'h493e_a0dd;
    int     mismatch_count = 0;
    int     timeout_count  = 0;
    logic   read_check_en;
    logic   idle_expected;

    save_state_top i_save_state_top (
        .clock            (clock),
        .reset_n          (reset_n),
        .core_write_en    (core_write_en),
        .core_write_addr  (core_write_addr),
        .core_write_data  (core_write_data),
        .core_read_addr   (core_read_addr),
        .core_read_data   (core_read_data),
        .begin_save_state (begin_save_state),
        .begin_load_state (begin_load_state),
        .slot             (slot),
        .stall            (stall)
    );

    bind save_state_controller save_state_props i_props (
        .clock          (clock),
        .reset_n        (reset_n),
        .stall          (stall),
        .state          (state),
        .slot_q         (slot_q),
        .state_write_en (state_write_en),
        .snap_write_en  (snap_write_en),
        .state_addr     (state_port.addr),
        .snap_addr      (snapshot_port.addr)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic save_state_pkg::word_t expected_word(
        input save_state_pkg::state_addr_t addr
    );
        return model_bank[addr];
    endfunction

    task automatic check_word(
        input save_state_pkg::word_t actual,
        input save_state_pkg::word_t expected,
        input string                 what
    );
        if (actual !== expected) begin
            mismatch_count++;
            $display("[FAIL] t=%0d ns: %s returned %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic check_stall(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            mismatch_count++;
            $display("[FAIL] t=%0d ns: %s, stall is %b, expected %b",
                     $time, what, actual, expected);
        end
    endtask

    task automatic check_busy_cycles(input int actual, input int expected, input string what);
        if (actual != expected) begin
            mismatch_count++;
            $display("[FAIL] t=%0d ns: %s held stall for %0d cycles, expected %0d",
                     $time, what, actual, expected);
        end
    endtask

    // reads are checked half a cycle after the address is driven.
    always @(negedge clock) begin
        if (read_check_en === 1'b1) begin
            check_word(core_read_data, expected_word(core_read_addr),
                       $sformatf("core read of word %0d", core_read_addr));
        end
        if (idle_expected === 1'b1) begin
            check_stall(stall, 1'b0, "stall while idle");
        end
    end

    task automatic write_all_random();
        int                          i;
        save_state_pkg::state_addr_t addr;
        save_state_pkg::word_t       data;
        for (i = 0; i < int'(save_state_pkg::state_words); i++) begin
            @(posedge clock);
            addr = save_state_pkg::state_addr_t'(i);
            data = save_state_pkg::word_t'($random(seed));
            core_write_en    <= 1'b1;
            core_write_addr  <= addr;
            core_write_data  <= data;
            idle_expected    <= 1'b1;
            model_bank[addr] = data;
        end
        @(posedge clock);
        core_write_en <= 1'b0;
    endtask

    task automatic write_scattered(input int count);
        int                          i;
        save_state_pkg::state_addr_t addr;
        save_state_pkg::word_t       data;
        for (i = 0; i < count; i++) begin
            @(posedge clock);
            addr = save_state_pkg::state_addr_t'($random(seed));
            data = save_state_pkg::word_t'($random(seed));
            core_write_en    <= 1'b1;
            core_write_addr  <= addr;
            core_write_data  <= data;
            idle_expected    <= 1'b1;
            model_bank[addr] = data; // later writes to the same word win.
        end
        @(posedge clock);
        core_write_en <= 1'b0;
    endtask

    task automatic read_all();
        int i;
        for (i = 0; i < int'(save_state_pkg::state_words); i++) begin
            @(posedge clock);
            core_read_addr <= save_state_pkg::state_addr_t'(i);
            read_check_en  <= 1'b1;
            idle_expected  <= 1'b1;
        end
        @(posedge clock);
        read_check_en <= 1'b0;
    endtask

    // a core write that the frozen bank must drop.
    task automatic drive_frozen_write(input bit enable);
        if (enable) begin
            core_write_en   <= 1'b1;
            core_write_addr <= save_state_pkg::state_addr_t'($random(seed));
            core_write_data <= save_state_pkg::word_t'($random(seed));
        end else begin
            core_write_en <= 1'b0;
        end
    endtask

    task automatic run_copy(
        input logic                  do_save,
        input logic                  do_load,
        input save_state_pkg::slot_t copy_slot,
        input bit                    write_during,
        input logic                  inject_save,
        input logic                  inject_load,
        input save_state_pkg::slot_t inject_slot,
        input string                 what
    );
        int                          busy;
        int                          i;
        bit                          done;
        save_state_pkg::state_addr_t addr;
        @(posedge clock);
        begin_save_state <= do_save;
        begin_load_state <= do_load;
        slot             <= copy_slot;
        idle_expected    <= 1'b0;
        drive_frozen_write(write_during);
        for (i = 0; i < int'(save_state_pkg::state_words); i++) begin
            addr = save_state_pkg::state_addr_t'(i);
            if (do_save) begin // save wins when both strobes are high.
                model_snap[copy_slot][addr] = model_bank[addr];
            end else if (do_load) begin
                model_bank[addr] = model_snap[copy_slot][addr];
            end
        end
        busy = 0;
        done = 1'b0;
        while (!done && busy < timeout_cycles) begin
            @(negedge clock);
            if (stall) begin
                busy++;
                @(posedge clock);
                begin_save_state <= inject_save && (busy == inject_cycle);
                begin_load_state <= inject_load && (busy == inject_cycle);
                if (busy == inject_cycle) begin
                    slot <= inject_slot;
                end
                drive_frozen_write(write_during && busy <= int'(save_state_pkg::state_words));
            end else begin
                done = 1'b1;
            end
        end
        if (done) begin
            check_busy_cycles(busy, copy_cycles, what);
        end else begin
            timeout_count++;
            $display("timeout: stall did not fall within %0d cycles during %s",
                     timeout_cycles, what);
        end
    endtask

    initial begin
        int                    i;
        int                    j;
        save_state_pkg::slot_t tmp;
        reset_n          = 1'b0;
        core_write_en    = 1'b0;
        core_write_addr  = '0;
        core_write_data  = '0;
        core_read_addr   = '0;
        begin_save_state = 1'b0;
        begin_load_state = 1'b0;
        slot             = '0;
        read_check_en    = 1'b0;
        idle_expected    = 1'b0;
        repeat (5) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        check_stall(stall, 1'b0, "stall after reset");

        // plain core traffic with no copy.
        write_all_random();
        write_scattered(8);
        read_all();

        // save to slot 2 while the core keeps writing.
        run_copy(1'b1, 1'b0, 2'd2, 1'b1, 1'b0, 1'b0, 2'd0, "save to slot 2");
        read_all();

        write_all_random();
        read_all();
        run_copy(1'b0, 1'b1, 2'd2, 1'b0, 1'b0, 1'b0, 2'd0, "load from slot 2");
        read_all();

        for (i = 0; i < int'(save_state_pkg::slot_count); i++) begin
            write_all_random();
            run_copy(1'b1, 1'b0, save_state_pkg::slot_t'(i), 1'b0, 1'b0, 1'b0, 2'd0,
                     $sformatf("save to slot %0d", i));
            order[save_state_pkg::slot_t'(i)] = save_state_pkg::slot_t'(i);
        end
        for (i = int'(save_state_pkg::slot_count) - 1; i > 0; i--) begin
            j = int'($unsigned($random(seed)) % (i + 1));
            tmp = order[save_state_pkg::slot_t'(i)];
            order[save_state_pkg::slot_t'(i)] = order[save_state_pkg::slot_t'(j)];
            order[save_state_pkg::slot_t'(j)] = tmp;
        end
        for (i = 0; i < int'(save_state_pkg::slot_count); i++) begin
            write_all_random();
            run_copy(1'b0, 1'b1, order[save_state_pkg::slot_t'(i)], 1'b0, 1'b0, 1'b0, 2'd0,
                     $sformatf("load from slot %0d", order[save_state_pkg::slot_t'(i)]));
            read_all();
        end

        // both strobes at once, and a load strobe in the middle that must be dropped.
        write_all_random();
        run_copy(1'b1, 1'b1, 2'd1, 1'b0, 1'b0, 1'b1, 2'd3, "save and load together");
        read_all();
        write_all_random();
        run_copy(1'b0, 1'b1, 2'd1, 1'b0, 1'b1, 1'b0, 2'd0, "load with a stray save");
        read_all();
        run_copy(1'b0, 1'b1, 2'd0, 1'b0, 1'b0, 1'b0, 2'd0, "load from slot 0");
        read_all();

        @(posedge clock);
        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : save_state_tb

// ==== list.f ====
source/save_state_pkg.sv
source/mem_port_if.sv
source/state_bank.sv
source/snapshot_ram.sv
source/save_state_controller.sv
source/save_state_top.sv
verification/save_state_props.sv
verification/save_state_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the save-state testbench with Verilator and runs it.
# The run counts as passed only if the log holds the pass message.

cd "$(dirname "$0")" || exit 1

log_file=sim.log
sim_name=save_state_sim

verilator --binary --timing --assert \
    -f list.f \
    --top-module save_state_tb \
    -o "$sim_name"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$sim_name" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# assertion failures show up as error lines in the log.
if grep -q "%Error" "$log_file"; then
    echo "assertion errors found in $log_file"
    exit 1
fi

if grep -q "All tests passed" "$log_file"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
